// File: logic/aluPkg.sv
/* ALU peripheral shared types */
package aluPkg;

	localparam int dataWidth = 16;	// One word
	localparam int addrWidth = 8;

	// Register map, byte offsets
	localparam logic [addrWidth-1:0] addrA      = 8'h00;
	localparam logic [addrWidth-1:0] addrB      = 8'h04;
	localparam logic [addrWidth-1:0] addrCmd    = 8'h08;
	localparam logic [addrWidth-1:0] addrResult = 8'h0C;
	localparam logic [addrWidth-1:0] addrFlags  = 8'h10;

	typedef enum logic [4:0] {
		opAdd  = 5'b00010,
		opAdc  = 5'b00100,
		opCmp  = 5'b00111,
		opSub  = 5'b01010,
		opSuc  = 5'b01100,
		opAnd  = 5'b10000,
		opOr   = 5'b10001,
		opNot  = 5'b10010,
		opXor  = 5'b10011,
		opLui  = 5'b10100,
		opLli  = 5'b10101,
		opNand = 5'b10110,
		opNor  = 5'b10111,
		opNop  = 5'b11000,
		opNeg  = 5'b11010,
		opAsr  = 5'b11100,
		opLsr  = 5'b11101,
		opLsl  = 5'b11111
	} aluOpE;

	// Same as the low three opcode bits of the logic group
	typedef enum logic [2:0] {
		logAnd  = 3'b000,
		logOr   = 3'b001,
		logNot  = 3'b010,
		logXor  = 3'b011,
		logNand = 3'b110,
		logNor  = 3'b111
	} logicOpE;

	typedef enum logic [1:0] {
		selAdder,
		selLogic,
		selShift,
		selNone
	} resSelE;

	typedef struct packed {
		logic c;
		logic v;
		logic n;
		logic z;
	} aluFlagsT;

	typedef struct packed {
		logic [3:0] imm4;	// pwdata 8:5
		aluOpE      opcode;	// pwdata 4:0
	} aluCmdT;

	typedef struct packed {
		resSelE     resSel;
		logic       sub;
		logic       zeroA;
		logic       cinSlice;
		logicOpE    logicOp;
		logic       shL;
		logic       shArith;
		logic [3:0] shAmt;	// Sh8 Sh4 Sh2 Sh1
		logic       shB;
		logic       lli;
		logic       writeResult;
		logic       setCV;
	} aluCtrlT;

	typedef struct packed {
		logic                 psel;
		logic                 penable;
		logic                 pwrite;
		logic [addrWidth-1:0] paddr;
		logic [dataWidth-1:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [dataWidth-1:0] prdata;
		logic                 pready;
		logic                 pslverr;
	} apbRspT;

endpackage

// File: logic/aluDecoder.sv
/* ALU opcode decoder */
`timescale 1ns/1ns

module aluDecoder (
	input  aluPkg::aluCmdT  cmd,
	input  logic            carry,
	output aluPkg::aluCtrlT ctrl
);
	import aluPkg::*;

	logic useCarry;	// ADC and SUC chain the stored carry

	always_comb
	begin
		ctrl = '0;
		ctrl.resSel = selNone;
		ctrl.logicOp = logAnd;
		ctrl.writeResult = 1'b1;
		useCarry = 1'b0;

		case (cmd.opcode)
			opAdd, opAdc, opSub, opSuc, opCmp, opNeg:
			begin
				ctrl.resSel = selAdder;
				ctrl.setCV = 1'b1;
				ctrl.sub = cmd.opcode inside {opSub, opSuc, opCmp, opNeg};
				ctrl.zeroA = (cmd.opcode == opNeg);	// 0 - B
				useCarry = cmd.opcode inside {opAdc, opSuc};
				ctrl.writeResult = (cmd.opcode != opCmp);	// CMP sets flags only
			end

			opAnd, opOr, opXor, opNot, opNand, opNor:
			begin
				ctrl.resSel = selLogic;
				ctrl.logicOp = logicOpE'(cmd.opcode[2:0]);
			end

			opLsl, opLsr, opAsr:
			begin
				ctrl.resSel = selShift;
				ctrl.shL = (cmd.opcode == opLsl);
				ctrl.shArith = (cmd.opcode == opAsr);
				ctrl.shAmt = cmd.imm4;
			end

			opLui:
			begin
				// High byte of B brought down
				ctrl.resSel = selShift;
				ctrl.shB = 1'b1;
				ctrl.shAmt = 4'b1000;	// Sh8 only
			end

			opLli:
			begin
				ctrl.resSel = selShift;
				ctrl.lli = 1'b1;
			end

			default: ctrl.writeResult = 1'b0;	// NOP and unused codes
		endcase

		// Carry in is the stored carry or the +1 of a subtract
		ctrl.cinSlice = useCarry ? carry : ctrl.sub;
	end

endmodule

// File: logic/aluAdder.sv
/* Adder and subtractor */
`timescale 1ns/1ns

module aluAdder (
	input  logic [aluPkg::dataWidth-1:0] a,
	input  logic [aluPkg::dataWidth-1:0] b,
	input  aluPkg::aluCtrlT              ctrl,
	output logic [aluPkg::dataWidth-1:0] sum,
	output logic                         cout,
	output logic                         ovf
);
	import aluPkg::*;

	logic [dataWidth-1:0] opA;	// A side, zero for NEG
	logic [dataWidth-1:0] opB;	// B or its inverse

	assign opA = ctrl.zeroA ? '0 : a;
	assign opB = ctrl.sub ? ~b : b;

	assign {cout, sum} = {1'b0, opA} + {1'b0, opB}
		+ {{dataWidth{1'b0}}, ctrl.cinSlice};

	// Like-signed operands giving an opposite-signed sum
	assign ovf = (opA[dataWidth-1] == opB[dataWidth-1])
		&& (sum[dataWidth-1] != opA[dataWidth-1]);

endmodule

// File: logic/aluLogicUnit.sv
/* Bitwise logic unit */
`timescale 1ns/1ns

module aluLogicUnit (
	input  logic [aluPkg::dataWidth-1:0] a,
	input  logic [aluPkg::dataWidth-1:0] b,
	input  aluPkg::aluCtrlT              ctrl,
	output logic [aluPkg::dataWidth-1:0] y
);
	import aluPkg::*;

	always_comb
	begin
		case (ctrl.logicOp)
			logAnd:  y = a & b;
			logOr:   y = a | b;
			logXor:  y = a ^ b;
			logNot:  y = ~a;	// B ignored
			logNand: y = ~(a & b);
			logNor:  y = ~(a | b);
			default: y = '0;
		endcase
	end

endmodule

// File: logic/aluShifter.sv
/* Barrel shifter and byte loads */
`timescale 1ns/1ns

module aluShifter (
	input  logic [aluPkg::dataWidth-1:0] a,
	input  logic [aluPkg::dataWidth-1:0] b,
	input  aluPkg::aluCtrlT              ctrl,
	output logic [aluPkg::dataWidth-1:0] y
);
	import aluPkg::*;

	logic [dataWidth-1:0] src;	// A, or B for LUI
	logic [dataWidth-1:0] st1;
	logic [dataWidth-1:0] st2;
	logic [dataWidth-1:0] st4;
	logic [dataWidth-1:0] st8;
	logic                 fill;	// Bit shifted in on the right shifts

	assign src = ctrl.shB ? b : a;
	assign fill = ctrl.shArith ? a[dataWidth-1] : 1'b0;

	// Four cascaded stages, one per bit of shAmt
	always_comb
	begin
		st1 = src;
		if (ctrl.shAmt[0])
			st1 = ctrl.shL ? {src[14:0], 1'b0} : {fill, src[15:1]};

		st2 = st1;
		if (ctrl.shAmt[1])
			st2 = ctrl.shL ? {st1[13:0], 2'b00} : {{2{fill}}, st1[15:2]};

		st4 = st2;
		if (ctrl.shAmt[2])
			st4 = ctrl.shL ? {st2[11:0], 4'h0} : {{4{fill}}, st2[15:4]};

		st8 = st4;
		if (ctrl.shAmt[3])
			st8 = ctrl.shL ? {st4[7:0], 8'h00} : {{8{fill}}, st4[15:8]};
	end

	assign y = ctrl.lli ? {8'h00, b[7:0]} : st8;	// LLI bypasses the stages

endmodule

// File: logic/aluResultSel.sv
/* Result select and flags */
`timescale 1ns/1ns

module aluResultSel (
	input  logic [aluPkg::dataWidth-1:0] sum,
	input  logic                         cout,
	input  logic                         ovf,
	input  logic [aluPkg::dataWidth-1:0] logicY,
	input  logic [aluPkg::dataWidth-1:0] shiftY,
	input  aluPkg::aluCtrlT              ctrl,
	input  aluPkg::aluFlagsT             flags,
	output logic [aluPkg::dataWidth-1:0] result,
	output aluPkg::aluFlagsT             nextFlags
);
	import aluPkg::*;

	logic keepAll;	// NOP and byte loads leave every flag alone

	assign keepAll = (ctrl.resSel == selNone) || ctrl.lli || ctrl.shB;

	always_comb
	begin
		case (ctrl.resSel)
			selAdder: result = sum;
			selLogic: result = logicY;
			selShift: result = shiftY;
			default:  result = '0;
		endcase

		nextFlags = flags;
		if (!keepAll)
		begin
			nextFlags.n = result[dataWidth-1];
			nextFlags.z = (result == '0);
		end

		// C and V only move on arithmetic
		if (ctrl.setCV)
		begin
			nextFlags.c = cout;
			nextFlags.v = ovf;
		end
	end

endmodule

// File: logic/aluApbRegs.sv
/* APB register block */
`timescale 1ns/1ns

module aluApbRegs (
	input  logic                         clk,
	input  logic                         arstN,
	input  aluPkg::apbReqT               apbReq,
	output aluPkg::apbRspT               apbRsp,
	output logic [aluPkg::dataWidth-1:0] a,
	output logic [aluPkg::dataWidth-1:0] b,
	output aluPkg::aluCmdT               cmd,
	output aluPkg::aluFlagsT             flags,
	input  logic [aluPkg::dataWidth-1:0] result,
	input  aluPkg::aluFlagsT             nextFlags,
	input  logic                         writeResult
);
	import aluPkg::*;

	typedef enum logic {
		stIdle,
		stCmdWait	// Second access cycle of a command write
	} regStateE;

	regStateE             state;
	logic [dataWidth-1:0] resultReg;
	logic [dataWidth-1:0] rdData;
	logic                 access;	// psel and penable
	logic                 hitA;
	logic                 hitB;
	logic                 hitCmd;
	logic                 hitResult;
	logic                 hitFlags;
	logic                 badAddr;
	logic                 cmdWrite;
	logic                 done;	// Transfer completes this edge
	logic                 slvErr;

	assign access = apbReq.psel && apbReq.penable;

	assign hitA = (apbReq.paddr == addrA);
	assign hitB = (apbReq.paddr == addrB);
	assign hitCmd = (apbReq.paddr == addrCmd);
	assign hitResult = (apbReq.paddr == addrResult);
	assign hitFlags = (apbReq.paddr == addrFlags);
	assign badAddr = !(hitA || hitB || hitCmd || hitResult || hitFlags);

	assign cmdWrite = access && apbReq.pwrite && hitCmd;
	assign done = access && !(cmdWrite && (state == stIdle));	// One wait on commands
	assign slvErr = done && (badAddr || (apbReq.pwrite && (hitResult || hitFlags)));

	// Reads have no side effect
	always_comb
	begin
		rdData = '0;
		if (access && !apbReq.pwrite)
		begin
			case (apbReq.paddr)
				addrA:      rdData = a;
				addrB:      rdData = b;
				addrCmd:    rdData[$bits(aluCmdT)-1:0] = cmd;
				addrResult: rdData = resultReg;
				addrFlags:  rdData[$bits(aluFlagsT)-1:0] = flags;
				default:    rdData = '0;
			endcase
		end
	end

	assign apbRsp = '{prdata: rdData, pready: done, pslverr: slvErr};

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			a <= '0;
			b <= '0;
			cmd <= '{imm4: 4'h0, opcode: opNop};
			resultReg <= '0;
			flags <= '0;
		end
		else
		begin
			if (done && apbReq.pwrite && hitA)
				a <= apbReq.pwdata;
			if (done && apbReq.pwrite && hitB)
				b <= apbReq.pwdata;

			case (state)
				stIdle:
				begin
					if (cmdWrite)
					begin
						cmd <= aluCmdT'(apbReq.pwdata[$bits(aluCmdT)-1:0]);
						state <= stCmdWait;
					end
				end
				stCmdWait:
				begin
					// Datapath now sees the new command
					if (writeResult)
						resultReg <= result;
					flags <= nextFlags;
					state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// File: logic/aluTop.sv
/* ALU peripheral top */
`timescale 1ns/1ns

module aluTop (
	input  logic           clk,
	input  logic           arstN,
	input  aluPkg::apbReqT apbReq,
	output aluPkg::apbRspT apbRsp
);
	import aluPkg::*;

	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	aluCmdT               cmd;
	aluFlagsT             flags;
	aluFlagsT             nextFlags;
	aluCtrlT              ctrl;
	logic [dataWidth-1:0] sum;
	logic                 cout;
	logic                 ovf;
	logic [dataWidth-1:0] logicY;
	logic [dataWidth-1:0] shiftY;
	logic [dataWidth-1:0] result;

	aluApbRegs aluApbRegs_inst (
		.clk         (clk),
		.arstN       (arstN),
		.apbReq      (apbReq),
		.apbRsp      (apbRsp),
		.a           (a),
		.b           (b),
		.cmd         (cmd),
		.flags       (flags),
		.result      (result),
		.nextFlags   (nextFlags),
		.writeResult (ctrl.writeResult)
	);

	aluDecoder aluDecoder_inst (
		.cmd   (cmd),
		.carry (flags.c),	// Stored carry for ADC and SUC
		.ctrl  (ctrl)
	);

	aluAdder aluAdder_inst (
		.a    (a),
		.b    (b),
		.ctrl (ctrl),
		.sum  (sum),
		.cout (cout),
		.ovf  (ovf)
	);

	aluLogicUnit aluLogicUnit_inst (
		.a    (a),
		.b    (b),
		.ctrl (ctrl),
		.y    (logicY)
	);

	aluShifter aluShifter_inst (
		.a    (a),
		.b    (b),
		.ctrl (ctrl),
		.y    (shiftY)
	);

	aluResultSel aluResultSel_inst (
		.sum       (sum),
		.cout      (cout),
		.ovf       (ovf),
		.logicY    (logicY),
		.shiftY    (shiftY),
		.ctrl      (ctrl),
		.flags     (flags),
		.result    (result),
		.nextFlags (nextFlags)
	);

endmodule

// File: verif/aluTb_assert.sv
/* APB protocol assertions */
`timescale 1ns/1ns

module apbProtocolCheck (
	input logic           clk,
	input logic           arstN,
	input aluPkg::apbReqT apbReq,
	input aluPkg::apbRspT apbRsp
);
	import aluPkg::*;

	logic access;
	logic cmdAccess;	// Access phase of a command write

	assign access = apbReq.psel && apbReq.penable;
	assign cmdAccess = access && apbReq.pwrite && (apbReq.paddr == addrCmd);

	errWithReady: assert property (@(posedge clk) disable iff (!arstN)
		apbRsp.pslverr |-> apbRsp.pready)
		else $error("pslverr high while pready is low");

	cmdFirstWait: assert property (@(posedge clk) disable iff (!arstN)
		(cmdAccess && $rose(apbReq.penable)) |-> !apbRsp.pready)
		else $error("command write completed without a wait state");

	cmdSecondReady: assert property (@(posedge clk) disable iff (!arstN)
		(cmdAccess && $rose(apbReq.penable)) |=> apbRsp.pready)
		else $error("command write took more than one wait state");

	readyInAccess: assert property (@(posedge clk) disable iff (!arstN)
		!access |-> !apbRsp.pready)
		else $error("pready high outside an access phase");

endmodule

bind aluApbRegs apbProtocolCheck apbProtocolCheck_inst (
	.clk    (clk),
	.arstN  (arstN),
	.apbReq (apbReq),
	.apbRsp (apbRsp)
);

// File: verif/aluTb.sv
/* ALU peripheral testbench */
`timescale 1ns/1ns

module aluTb;
	import aluPkg::*;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 5;
	localparam int randomTests = 40;
	localparam int cyclesPerTest = 20;	// Watchdog budget per command
	localparam aluOpE randomOps [4] = '{opAdd, opSub, opXor, opLsr};

	typedef struct packed {
		logic [4:0]  op;
		logic [3:0]  imm;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		aluFlagsT    flags;
	} vectorT;

	logic   clk;
	logic   arstN;
	apbReqT apbReq;
	apbRspT apbRsp;
	vectorT vectors [$];
	logic   vectorsReady;
	int     seed = 2680;
	int     passCount;
	int     failCount;

	aluTop aluTop_inst (
		.clk    (clk),
		.arstN  (arstN),
		.apbReq (apbReq),
		.apbRsp (apbRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Reference of the instruction rules for the random commands
	function automatic logic [19:0] refModel(input aluOpE op, input logic [3:0] imm,
		input logic [15:0] a, input logic [15:0] b, input aluFlagsT flg);
		logic [16:0] wide;
		logic [15:0] res;
		aluFlagsT    nf;
		nf = flg;
		case (op)
			opAdd:
			begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[15:0];
				nf.c = wide[16];
				nf.v = (a[15] == b[15]) && (res[15] != a[15]);
			end
			opSub:
			begin
				res = a - b;
				nf.c = (a >= b);	// No borrow
				nf.v = (a[15] != b[15]) && (res[15] != a[15]);
			end
			opXor: res = a ^ b;	// C and V kept
			default: res = a >> imm;
		endcase
		nf.n = res[15];
		nf.z = (res == 16'h0000);
		return {res, nf};
	endfunction

	task automatic checkValue(input string what, input logic [15:0] got,
		input logic [15:0] exp, inout bit ok);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic reportTest(input string name, input bit ok);
		if (ok)
			passCount++;
		else
			failCount++;
		$display("%-24s %s", name, ok ? "ok" : "FAILED");
	endtask

	// One APB transfer, setup then access until pready
	task automatic apbXfer(input logic write, input logic [7:0] addr, input logic [15:0] wdata,
		output logic [15:0] rdata, output logic err, output int waits);
		@(posedge clk);
		apbReq.psel <= 1'b1;
		apbReq.penable <= 1'b0;
		apbReq.pwrite <= write;
		apbReq.paddr <= addr;
		apbReq.pwdata <= wdata;
		@(posedge clk);
		apbReq.penable <= 1'b1;
		waits = 0;
		@(posedge clk);
		while (!apbRsp.pready)
		begin
			waits++;
			@(posedge clk);
		end
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		apbReq.psel <= 1'b0;
		apbReq.penable <= 1'b0;
	endtask

	// Data is the write data, or the expected read data
	task automatic xferCheck(input logic write, input logic [7:0] addr, input logic [15:0] data,
		input logic expErr, input int expWaits, inout bit ok);
		logic [15:0] rd;
		logic        err;
		int          waits;
		apbXfer(write, addr, data, rd, err, waits);
		if (!write)
			checkValue($sformatf("read data at %h", addr), rd, data, ok);
		checkValue($sformatf("pslverr at %h", addr), {15'b0, err}, {15'b0, expErr}, ok);
		checkValue($sformatf("wait states at %h", addr), 16'(waits), 16'(expWaits), ok);
	endtask

	task automatic runCommand(input string name, input aluOpE op, input logic [3:0] imm,
		input logic [15:0] a, input logic [15:0] b, input logic [15:0] expRes,
		input aluFlagsT expFlags);
		bit ok;
		ok = 1'b1;
		xferCheck(1'b1, addrA, a, 1'b0, 0, ok);
		xferCheck(1'b1, addrB, b, 1'b0, 0, ok);
		xferCheck(1'b1, addrCmd, {7'b0, imm, op}, 1'b0, 1, ok);	// One wait state
		xferCheck(1'b0, addrResult, expRes, 1'b0, 0, ok);
		xferCheck(1'b0, addrFlags, {12'b0, expFlags}, 1'b0, 0, ok);
		reportTest(name, ok);
	endtask

	task automatic loadVectors(output bit opened);
		int          fd;
		string       line;
		vectorT      vec;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
		fd = $fopen("verif/aluVectors.txt", "r");
		opened = (fd != 0);
		if (opened)
		begin
			while (!$feof(fd))
			begin
				void'($fgets(line, fd));
				// Comment and blank lines do not scan
				if ($sscanf(line, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5) == 6)
				begin
					vec = {f0[4:0], f1[3:0], f2[15:0], f3[15:0], f4[15:0], f5[3:0]};
					vectors.push_back(vec);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic registerTests();
		bit ok;
		ok = 1'b1;
		checkValue("pready after reset", {15'b0, apbRsp.pready}, 16'h0000, ok);
		checkValue("pslverr after reset", {15'b0, apbRsp.pslverr}, 16'h0000, ok);
		xferCheck(1'b0, addrA, 16'h0000, 1'b0, 0, ok);
		xferCheck(1'b0, addrB, 16'h0000, 1'b0, 0, ok);
		xferCheck(1'b0, addrCmd, 16'h0018, 1'b0, 0, ok);	// NOP
		xferCheck(1'b0, addrResult, 16'h0000, 1'b0, 0, ok);
		xferCheck(1'b0, addrFlags, 16'h0000, 1'b0, 0, ok);
		reportTest("reset state", ok);

		ok = 1'b1;
		xferCheck(1'b1, addrA, 16'hA5C3, 1'b0, 0, ok);
		xferCheck(1'b1, addrB, 16'h3C5A, 1'b0, 0, ok);
		xferCheck(1'b1, addrCmd, 16'h0158, 1'b0, 1, ok);	// NOP with imm4 1010
		xferCheck(1'b0, addrA, 16'hA5C3, 1'b0, 0, ok);
		xferCheck(1'b0, addrB, 16'h3C5A, 1'b0, 0, ok);
		xferCheck(1'b0, addrCmd, 16'h0158, 1'b0, 0, ok);
		xferCheck(1'b1, 8'h20, 16'h1234, 1'b1, 0, ok);	// Unknown address
		xferCheck(1'b0, 8'h14, 16'h0000, 1'b1, 0, ok);
		xferCheck(1'b1, addrResult, 16'hFFFF, 1'b1, 0, ok);	// Read-only
		xferCheck(1'b1, addrFlags, 16'h000F, 1'b1, 0, ok);
		xferCheck(1'b0, addrResult, 16'h0000, 1'b0, 0, ok);
		xferCheck(1'b0, addrFlags, 16'h0000, 1'b0, 0, ok);
		reportTest("register access", ok);
	endtask

	task automatic randomTestsRun();
		aluOpE       op;
		logic [15:0] a;
		logic [15:0] b;
		logic [3:0]  imm;
		logic [19:0] modelOut;
		aluFlagsT    flg;
		flg = vectors[vectors.size() - 1].flags;	// State left by the vectors
		for (int i = 0; i < randomTests; i++)
		begin
			op = randomOps[$unsigned($random(seed)) % 4];
			a = 16'($random(seed));
			b = 16'($random(seed));
			imm = 4'($random(seed));
			modelOut = refModel(op, imm, a, b, flg);
			flg = modelOut[3:0];
			runCommand($sformatf("random %0d %s", i, op.name()), op, imm, a, b,
				modelOut[19:4], flg);
		end
	endtask

	initial
	begin
		bit opened;
		apbReq = '0;
		arstN = 1'b0;
		passCount = 0;
		failCount = 0;
		vectorsReady = 1'b0;
		loadVectors(opened);
		if (!opened)
		begin
			$display("Could not open the vector file verif/aluVectors.txt");
			$display("sim failed");
			$finish;
		end
		else
		begin
			vectorsReady = 1'b1;
			repeat (resetCycles) @(posedge clk);
			arstN <= 1'b1;

			registerTests();
			foreach (vectors[i])
				runCommand($sformatf("vector %0d", i), aluOpE'(vectors[i].op), vectors[i].imm,
					vectors[i].a, vectors[i].b, vectors[i].res, vectors[i].flags);
			randomTestsRun();

			$display("Tests passed: %0d, failed: %0d", passCount, failCount);
			if (failCount == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
		end
	end

	// Watchdog sized from the number of commands
	initial
	begin
		wait (vectorsReady);
		#((vectors.size() + randomTests) * cyclesPerTest * clkPeriod + resetCycles * clkPeriod);
		$display("The run timed out before all tests finished");
		$display("sim failed");
		$finish;
	end

endmodule

// File: verif/aluVectors.txt
# Columns, all hex: opcode imm4 A B result flags
# Flags are C V N Z from bit 3 down to bit 0, applied in order
02 0 1234 4321 5555 0
02 0 7FFF 0001 8000 6
0A 0 0005 0007 FFFE 2
0A 0 8000 0001 7FFF C
07 0 0003 0003 7FFF 9
1A 0 1234 8000 8000 6
02 0 FFFF 0001 0000 9
04 0 0001 0002 0004 0
0A 0 0000 0001 FFFF 2
0C 0 0005 0001 0003 8
10 0 F0F0 FF00 F000 A
02 0 7FFF 7FFF FFFE 6
11 0 F0F0 0F0F FFFF 6
13 0 AAAA AAAA 0000 5
12 0 00FF 1234 FF00 6
16 0 FFFF FFFF 0000 5
17 0 0F00 00F0 F00F 6
1F 4 1234 0000 2340 4
1D F 8000 0000 0001 4
1C 3 8010 0000 F002 6
1D 8 ABCD 0000 00AB 4
15 0 1111 ABCD 00CD 4
14 0 1111 12CD 0012 4
18 0 FFFF FFFF 0012 4
1E 0 FFFF FFFF 0012 4

// File: aluAlu.f
logic/aluPkg.sv
logic/aluDecoder.sv
logic/aluAdder.sv
logic/aluLogicUnit.sv
logic/aluShifter.sv
logic/aluResultSel.sv
logic/aluApbRegs.sv
logic/aluTop.sv
verif/aluTb_assert.sv
verif/aluTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aluTb -f aluAlu.f -o simAlu

./obj_dir/simAlu 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
